// File: decoder_cases.txt
# instr rs1 rs2 rd imm branch_mask funct3 ctrl
# all columns hex with ctrl as the 17-bit packed control word
002081b3 01 02 03 00000002 00 0 00020  # add x3, x1, x2
407302b3 06 07 05 00000407 00 0 01020  # sub x5, x6, x7
40c5d533 0b 0c 0a 0000040c 00 5 07020  # sra x10, x11, x12
022081b3 01 02 03 00000022 00 0 0a020  # mul
022091b3 01 02 03 00000022 00 1 0b020  # mulh
0220a1b3 01 02 03 00000022 00 2 0c020  # mulhsu
0220b1b3 01 02 03 00000022 00 3 0d020  # mulhu
0220c1b3 01 02 03 00000022 00 4 0e020  # div
0220d1b3 01 02 03 00000022 00 5 0f020  # divu
0220e1b3 01 02 03 00000022 00 6 10020  # rem
0220f1b3 01 02 03 00000022 00 7 11020  # remu
fff10093 02 1f 01 ffffffff 00 0 00220  # addi x1, x2, -1
40345393 08 03 07 00000403 00 5 07220  # srai x7, x8, 3
7ff53493 0a 1f 09 000007ff 00 3 04220  # sltiu x9, x10, 0x7ff
ffc32283 06 1c 05 fffffffc 00 2 00240  # lw x5, -4(x6)
00742a23 08 07 14 00000014 00 2 00280  # sw x7, 20(x8)
fe112c23 02 01 18 fffffff8 00 2 00280  # sw x1, -8(x2)
00208463 01 02 08 00000008 01 0 000c0  # beq x1, x2, +8
fe419ee3 03 04 1d fffffffc 02 1 000c0  # bne x3, x4, -4
0062c863 05 06 10 00000010 04 4 000c0  # blt x5, x6, +16
0083d0e3 07 08 01 00000800 08 5 000c0  # bge x7, x8, +2048
80a4e063 09 0a 00 fffff000 10 6 000c0  # bltu x9, x10, -4096
02c5f063 0b 0c 00 00000020 20 7 000c0  # bgeu x11, x12, +32
001000ef 00 01 01 00000800 00 0 00a0b  # jal x1, +2048
fffff06f 1f 1f 00 fffffffe 00 7 00a0b  # jal x0, -2
000012ef 00 00 05 00001000 00 1 00a0b  # jal x5, +4096
00c280e7 05 0c 01 0000000c 00 0 0020b  # jalr x1, 12(x5)
12345197 08 03 03 12345000 00 5 00a20  # auipc x3, 0x12345
fedcb537 19 0d 0a fedcb000 00 3 00014  # lui x10, 0xfedcb
0ff0000f 00 1f 00 000000ff 00 0 00000  # fence
00000073 00 00 00 00000000 00 0 00100  # ecall
1234500b 08 03 00 00000123 00 5 00140  # custom-0, undefined
0000545a 02 16 08 000000b4 00 2 00240  # c.lwsp x8, 180(sp)
00004012 02 04 00 00000004 00 2 00380  # c.lwsp x0, reserved
00008282 05 00 05 00000000 00 2 0000b  # c.jr x5
0000831e 00 07 06 00000000 00 2 00020  # c.mv x6, x7
0000931e 06 07 06 00000000 00 2 00020  # c.add x6, x7
00009282 05 00 05 00000000 00 2 00180  # c.jalr x5
00009002 00 00 00 00000000 00 2 00180  # c.ebreak
0000c426 02 09 08 00000000 00 2 00180  # c.swsp x9, 8(sp)
00000506 0a 01 0a 00000000 00 2 00180  # c.slli x10, 1
00004108 02 02 02 00000000 00 2 00180  # quadrant c0
00000085 01 01 01 00000000 00 2 00000  # c.addi x1, 1 in quadrant c1

// File: decoder_consts.svh
`ifndef DECODER_CONSTS_SVH
`define DECODER_CONSTS_SVH

// datapath width of the core
`define XLEN 32

// register specifier width, x0..x31
`define REG_IDX_W 5

// one bit per branch compare, beq bne blt bge bltu bgeu
`define BRANCH_MASK_W 6

// fixed architectural registers
`define SP_REG_IDX 5'd2      // x2, stack pointer for c.lwsp / c.swsp
`define ZERO_REG_IDX 5'd0    // x0, hardwired zero

`endif

// File: exec_ctrl_pkg.sv
`default_nettype none

package exec_ctrl_pkg;

   typedef enum logic [4:0] {
      ALUOP_ADD    = 5'd0,
      ALUOP_SUB    = 5'd1,
      ALUOP_SLL    = 5'd2,
      ALUOP_SLT    = 5'd3,
      ALUOP_SLTU   = 5'd4,
      ALUOP_XOR    = 5'd5,
      ALUOP_SRL    = 5'd6,
      ALUOP_SRA    = 5'd7,
      ALUOP_OR     = 5'd8,
      ALUOP_AND    = 5'd9,
      ALUOP_MUL    = 5'd10,          // M ops follow funct3 order from here
      ALUOP_MULH   = 5'd11,
      ALUOP_MULHSU = 5'd12,
      ALUOP_MULHU  = 5'd13,
      ALUOP_DIV    = 5'd14,
      ALUOP_DIVU   = 5'd15,
      ALUOP_REM    = 5'd16,
      ALUOP_REMU   = 5'd17
   } alu_op_e;

   typedef enum logic {
      S1_REGVAL1 = 1'b0,
      S1_PC      = 1'b1
   } alu_s1_sel_e;

   typedef enum logic [1:0] {
      S2_REGVAL2 = 2'd0,
      S2_IMM     = 2'd1
   } alu_s2_sel_e;

   typedef enum logic [1:0] {
      REGIN_NONE = 2'd0,
      REGIN_ALU  = 2'd1,
      REGIN_IMM  = 2'd2
   } reg_input_sel_e;

   typedef enum logic [2:0] {
      EXEC_TO_FETCH  = 3'd0,
      EXEC_TO_LOAD   = 3'd1,
      EXEC_TO_STORE  = 3'd2,
      EXEC_TO_BRANCH = 3'd3,
      EXEC_TO_SYSTEM = 3'd4,
      EXEC_TO_TRAP   = 3'd5,
      EXEC_TO_DEAD   = 3'd6            // unsupported encoding, core halts
   } next_stage_e;

   typedef struct packed {
      alu_op_e        alu_oper;
      alu_s1_sel_e    s1_sel;
      alu_s2_sel_e    s2_sel;
      next_stage_e    next_stage;
      logic           wb_from_alu;
      logic           wb_from_imm;
      logic           next_pc_from_alu;
      reg_input_sel_e reg_input_sel;
      logic           write_reg;         // return address write in decode
   } dec_ctrl_t;

   // plain add, no writeback, back to fetch
   localparam dec_ctrl_t DEC_CTRL_DEFAULT = '{
      alu_oper:         ALUOP_ADD,
      s1_sel:           S1_REGVAL1,
      s2_sel:           S2_REGVAL2,
      next_stage:       EXEC_TO_FETCH,
      wb_from_alu:      1'b0,
      wb_from_imm:      1'b0,
      next_pc_from_alu: 1'b0,
      reg_input_sel:    REGIN_NONE,
      write_reg:        1'b0
   };

endpackage

`default_nettype wire

// File: riscv_isa_pkg.sv
`default_nettype none
`include "decoder_consts.svh"

package riscv_isa_pkg;

   typedef logic [2:0] funct3_t;   // minor opcode, instr[14:12]
   typedef logic [6:0] funct7_t;   // instr[31:25]

   typedef enum logic [4:0] {      // major opcode, instr[6:2]
      OPC_LOAD    = 5'b00000,
      OPC_MISCMEM = 5'b00011,
      OPC_OPIMM   = 5'b00100,
      OPC_AUIPC   = 5'b00101,
      OPC_STORE   = 5'b01000,
      OPC_OP      = 5'b01100,
      OPC_LUI     = 5'b01101,
      OPC_BRANCH  = 5'b11000,
      OPC_JALR    = 5'b11001,
      OPC_JAL     = 5'b11011,
      OPC_SYSTEM  = 5'b11100
   } opcode_e;

   typedef enum logic [1:0] {      // instr[1:0]
      QUAD_C0   = 2'd0,
      QUAD_C1   = 2'd1,
      QUAD_C2   = 2'd2,
      QUAD_BASE = 2'd3               // 32-bit encoding
   } c_quad_e;

   typedef enum logic [2:0] {      // quadrant 2 funct3, instr[15:13]
      C2_SLLI  = 3'd0,
      C2_FLDSP = 3'd1,
      C2_LWSP  = 3'd2,
      C2_FLWSP = 3'd3,
      C2_JR    = 3'd4,               // also mv, add, jalr, ebreak
      C2_FSDSP = 3'd5,
      C2_SWSP  = 3'd6,
      C2_FSWSP = 3'd7
   } c2_funct3_e;

   localparam funct3_t FUNC_LW   = 3'd2;   // reported for all compressed forms
   localparam funct3_t FUNC_BEQ  = 3'd0;
   localparam funct3_t FUNC_BNE  = 3'd1;
   localparam funct3_t FUNC_BLT  = 3'd4;
   localparam funct3_t FUNC_BGE  = 3'd5;
   localparam funct3_t FUNC_BLTU = 3'd6;
   localparam funct3_t FUNC_BGEU = 3'd7;

   localparam funct7_t FUNCT7_ALT    = 7'b0100000;   // sub / sra
   localparam funct7_t FUNCT7_MULDIV = 7'b0000001;   // M extension

   typedef struct packed {
      logic [`REG_IDX_W-1:0] rs1;
      logic [`REG_IDX_W-1:0] rs2;
      logic [`REG_IDX_W-1:0] rd;
   } reg_sel_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb_rv_decoder -o tb_rv_decoder_sim

./obj_dir/tb_rv_decoder_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
   exit 1
fi

// File: rv_base_ctrl_dec.sv
`timescale 1ns/10ps
`default_nettype none
`include "decoder_consts.svh"

module rv_base_ctrl_dec
   import riscv_isa_pkg::*;
   import exec_ctrl_pkg::*;
(
   input  wire  [`XLEN-1:0]          i_instr,
   output reg_sel_t                  o_regs,
   output dec_ctrl_t                 o_ctrl,
   output funct3_t                   o_funct3,
   output logic [`BRANCH_MASK_W-1:0] o_branch_mask
);

   opcode_e opcode;
   funct3_t funct3;
   funct7_t funct7;

   assign opcode = opcode_e'(i_instr[6:2]);
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   // fixed field positions so the regfile can be read during decode
   assign o_regs   = '{rs1: i_instr[19:15], rs2: i_instr[24:20], rd: i_instr[11:7]};
   assign o_funct3 = funct3;

   // shared by OP and OP-IMM, variants patched afterwards
   function automatic alu_op_e base_alu_op(input funct3_t f3);
      case (f3)
         3'd0:    return ALUOP_ADD;
         3'd1:    return ALUOP_SLL;
         3'd2:    return ALUOP_SLT;
         3'd3:    return ALUOP_SLTU;
         3'd4:    return ALUOP_XOR;
         3'd5:    return ALUOP_SRL;
         3'd6:    return ALUOP_OR;
         default: return ALUOP_AND;
      endcase
   endfunction

   always_comb begin
      o_ctrl = DEC_CTRL_DEFAULT;
      case (opcode)
         OPC_OP: begin
            o_ctrl.alu_oper = base_alu_op(funct3);
            if (funct7 == FUNCT7_MULDIV)                  // mul..remu in funct3 order
               o_ctrl.alu_oper = alu_op_e'(5'(ALUOP_MUL) + 5'(funct3));
            else if (funct7 == FUNCT7_ALT && funct3 == 3'd0)
               o_ctrl.alu_oper = ALUOP_SUB;
            else if (funct7 == FUNCT7_ALT && funct3 == 3'd5)
               o_ctrl.alu_oper = ALUOP_SRA;
            o_ctrl.wb_from_alu = 1'b1;                    // rd written back in fetch
         end
         OPC_OPIMM: begin
            o_ctrl.alu_oper = base_alu_op(funct3);
            if (funct3 == 3'd5 && funct7[5])              // srai
               o_ctrl.alu_oper = ALUOP_SRA;
            o_ctrl.s2_sel      = S2_IMM;
            o_ctrl.wb_from_alu = 1'b1;
         end
         OPC_LOAD: begin                                  // address = rs1 + imm
            o_ctrl.s2_sel     = S2_IMM;
            o_ctrl.next_stage = EXEC_TO_LOAD;
         end
         OPC_STORE: begin
            o_ctrl.s2_sel     = S2_IMM;
            o_ctrl.next_stage = EXEC_TO_STORE;
         end
         OPC_JAL, OPC_JALR: begin
            o_ctrl.write_reg        = 1'b1;               // link written in decode
            o_ctrl.reg_input_sel    = REGIN_ALU;
            o_ctrl.s1_sel           = (opcode == OPC_JAL) ? S1_PC : S1_REGVAL1;
            o_ctrl.s2_sel           = S2_IMM;
            o_ctrl.next_pc_from_alu = 1'b1;               // target from alu sum
         end
         OPC_BRANCH:  o_ctrl.next_stage = EXEC_TO_BRANCH; // compare rs1 vs rs2
         OPC_AUIPC: begin                                 // pc + imm
            o_ctrl.s1_sel      = S1_PC;
            o_ctrl.s2_sel      = S2_IMM;
            o_ctrl.wb_from_alu = 1'b1;
         end
         OPC_LUI: begin
            o_ctrl.wb_from_imm   = 1'b1;
            o_ctrl.reg_input_sel = REGIN_IMM;
         end
         OPC_MISCMEM: o_ctrl.next_stage = EXEC_TO_FETCH;  // fence as nop
         OPC_SYSTEM:  o_ctrl.next_stage = EXEC_TO_SYSTEM;
         default:     o_ctrl.next_stage = EXEC_TO_TRAP;   // unknown opcode
      endcase
   end

   always_comb begin
      o_branch_mask = '0;
      if (opcode == OPC_BRANCH) begin
         case (funct3)
            FUNC_BEQ:  o_branch_mask[0] = 1'b1;
            FUNC_BNE:  o_branch_mask[1] = 1'b1;
            FUNC_BLT:  o_branch_mask[2] = 1'b1;
            FUNC_BGE:  o_branch_mask[3] = 1'b1;
            FUNC_BLTU: o_branch_mask[4] = 1'b1;
            FUNC_BGEU: o_branch_mask[5] = 1'b1;
            default:   o_branch_mask    = '0;           // 2 and 3 are not branches
         endcase
      end
   end

   // branch unit picks exactly one compare, never two
   always_comb begin
      assert ($onehot0(o_branch_mask))
         else $error("branch mask %b not one-hot for opcode %h", o_branch_mask, opcode);
   end

endmodule

`default_nettype wire

// File: rv_compressed_ctrl_dec.sv
`timescale 1ns/10ps
`default_nettype none
`include "decoder_consts.svh"

module rv_compressed_ctrl_dec
   import riscv_isa_pkg::*;
   import exec_ctrl_pkg::*;
(
   input  wire [`XLEN-1:0] i_instr,
   output reg_sel_t        o_regs,
   output dec_ctrl_t       o_ctrl
);

   c_quad_e                quad;
   c2_funct3_e             c_funct3;
   logic [`REG_IDX_W-1:0]  c_rs1;                // rs1 and rd share 11:7
   logic [`REG_IDX_W-1:0]  c_rs2;

   assign quad     = c_quad_e'(i_instr[1:0]);
   assign c_funct3 = c2_funct3_e'(i_instr[15:13]);
   assign c_rs1    = i_instr[11:7];
   assign c_rs2    = i_instr[6:2];

   always_comb begin
      o_regs = '{rs1: c_rs1, rs2: c_rs2, rd: c_rs1};
      o_ctrl = DEC_CTRL_DEFAULT;
      case (quad)
         QUAD_C1: o_ctrl.next_stage = EXEC_TO_FETCH;      // whole quadrant as nop
         QUAD_C2: begin
            case (c_funct3)
               C2_LWSP: begin                             // sp + scaled offset
                  o_regs.rs1        = `SP_REG_IDX;
                  o_ctrl.s2_sel     = S2_IMM;
                  o_ctrl.next_stage = (c_rs1 == `ZERO_REG_IDX) ? EXEC_TO_DEAD : EXEC_TO_LOAD;
               end
               C2_JR: begin
                  if (!i_instr[12]) begin
                     if (c_rs2 != `ZERO_REG_IDX) begin    // c.mv, rd = x0 + rs2
                        o_regs.rs1         = `ZERO_REG_IDX;
                        o_ctrl.wb_from_alu = 1'b1;
                     end else if (c_rs1 == `ZERO_REG_IDX) begin
                        o_ctrl.next_stage = EXEC_TO_DEAD; // reserved jr x0
                     end else begin                       // c.jr
                        o_ctrl.write_reg        = 1'b1;
                        o_ctrl.reg_input_sel    = REGIN_ALU;
                        o_ctrl.next_pc_from_alu = 1'b1;
                     end
                  end else begin
                     if (c_rs2 != `ZERO_REG_IDX && c_rs1 != `ZERO_REG_IDX)
                        o_ctrl.wb_from_alu = 1'b1;        // c.add
                     else
                        o_ctrl.next_stage = EXEC_TO_DEAD; // jalr, ebreak, add hint
                  end
               end
               C2_SWSP: begin                             // store path not wired
                  o_regs.rs1        = `SP_REG_IDX;
                  o_ctrl.next_stage = EXEC_TO_DEAD;
               end
               default: o_ctrl.next_stage = EXEC_TO_DEAD; // slli, fp forms
            endcase
         end
         default: o_ctrl.next_stage = EXEC_TO_DEAD;       // c0, base never picked here
      endcase
   end

   // a dead instruction must leave the register file untouched
   always_comb begin
      assert (o_ctrl.next_stage != EXEC_TO_DEAD || (!o_ctrl.write_reg && !o_ctrl.wb_from_alu))
         else $error("dead stage with register write, instr %h", i_instr[15:0]);
   end

endmodule

`default_nettype wire

// File: rv_decode_reg.sv
`timescale 1ns/10ps
`default_nettype none
`include "decoder_consts.svh"

module rv_decode_reg
   import riscv_isa_pkg::*;
   import exec_ctrl_pkg::*;
(
   input  wire                       i_clk,
   input  wire                       i_rst_n,
   input  wire                       i_en,
   input  wire  [`XLEN-1:0]          i_instr,
   input  wire  [`XLEN-1:0]          i_imm,
   input  wire  reg_sel_t            i_base_regs,
   input  wire  dec_ctrl_t           i_base_ctrl,
   input  wire  funct3_t             i_funct3,
   input  wire  [`BRANCH_MASK_W-1:0] i_branch_mask,
   input  wire  reg_sel_t            i_c_regs,
   input  wire  dec_ctrl_t           i_c_ctrl,
   output logic                      o_valid,
   output reg_sel_t                  o_regs,
   output logic [`XLEN-1:0]          o_imm,
   output logic [`BRANCH_MASK_W-1:0] o_branch_mask,
   output funct3_t                   o_funct3,
   output dec_ctrl_t                 o_ctrl
);

   logic is_base;

   assign is_base = (c_quad_e'(i_instr[1:0]) == QUAD_BASE);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid <= 1'b0;
         o_ctrl  <= DEC_CTRL_DEFAULT;                     // no writes and back to fetch
      end else begin
         o_valid <= i_en;                                 // one pulse per enable
         if (i_en)
            o_ctrl <= is_base ? i_base_ctrl : i_c_ctrl;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_en) begin                                     // hold last result when idle
         o_regs        <= is_base ? i_base_regs : i_c_regs;
         o_imm         <= i_imm;
         o_funct3      <= is_base ? i_funct3 : FUNC_LW;   // c forms report lw
         o_branch_mask <= is_base ? i_branch_mask : '0;
      end
   end

   // a registered compare only travels with the branch stage
   assert property (@(posedge i_clk) disable iff (!i_rst_n)
                    o_valid && (o_branch_mask != '0) |-> o_ctrl.next_stage == EXEC_TO_BRANCH)
      else $error("branch mask %b without branch stage", o_branch_mask);

endmodule

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "decoder_consts.svh"

module rv_decoder
   import riscv_isa_pkg::*;
   import exec_ctrl_pkg::*;
(
   input  wire                       i_clk,
   input  wire                       i_rst_n,
   input  wire                       i_en,           // one instruction per high cycle
   input  wire  [`XLEN-1:0]          i_instr,
   output logic                      o_valid,
   output reg_sel_t                  o_regs,
   output logic [`XLEN-1:0]          o_imm,
   output logic [`BRANCH_MASK_W-1:0] o_branch_mask,
   output funct3_t                   o_funct3,
   output dec_ctrl_t                 o_ctrl
);

   logic [`XLEN-1:0]          imm;
   reg_sel_t                  base_regs;
   dec_ctrl_t                 base_ctrl;
   funct3_t                   funct3;
   logic [`BRANCH_MASK_W-1:0] branch_mask;
   reg_sel_t                  c_regs;
   dec_ctrl_t                 c_ctrl;

   rv_imm_gen imm_gen_inst (
      .i_instr (i_instr),
      .o_imm   (imm)
   );

   rv_base_ctrl_dec base_dec_inst (
      .i_instr       (i_instr),
      .o_regs        (base_regs),
      .o_ctrl        (base_ctrl),
      .o_funct3      (funct3),
      .o_branch_mask (branch_mask)
   );

   rv_compressed_ctrl_dec c_dec_inst (
      .i_instr (i_instr),
      .o_regs  (c_regs),
      .o_ctrl  (c_ctrl)
   );

   rv_decode_reg decode_reg_inst (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_en          (i_en),
      .i_instr       (i_instr),
      .i_imm         (imm),
      .i_base_regs   (base_regs),
      .i_base_ctrl   (base_ctrl),
      .i_funct3      (funct3),
      .i_branch_mask (branch_mask),
      .i_c_regs      (c_regs),
      .i_c_ctrl      (c_ctrl),
      .o_valid       (o_valid),
      .o_regs        (o_regs),
      .o_imm         (o_imm),
      .o_branch_mask (o_branch_mask),
      .o_funct3      (o_funct3),
      .o_ctrl        (o_ctrl)
   );

endmodule

`default_nettype wire

// File: rv_imm_gen.sv
`timescale 1ns/10ps
`default_nettype none
`include "decoder_consts.svh"

module rv_imm_gen
   import riscv_isa_pkg::*;
(
   input  wire  [`XLEN-1:0] i_instr,
   output logic [`XLEN-1:0] o_imm
);

   opcode_e    opcode;
   c_quad_e    quad;
   c2_funct3_e c_funct3;

   assign opcode   = opcode_e'(i_instr[6:2]);
   assign quad     = c_quad_e'(i_instr[1:0]);
   assign c_funct3 = c2_funct3_e'(i_instr[15:13]);

   always_comb begin
      o_imm = '0;                                         // unused compressed forms
      case (quad)
         QUAD_BASE: begin
            case (opcode)
               OPC_STORE:                                 // S form
                  o_imm = {{(`XLEN-11){i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
               OPC_BRANCH:                                // B form, bit 0 implied
                  o_imm = {{(`XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                           i_instr[11:8], 1'b0};
               OPC_LUI, OPC_AUIPC:                        // U form, upper 20
                  o_imm = {i_instr[31:12], 12'b0};
               OPC_JAL:                                   // J form
                  o_imm = {{(`XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                           i_instr[30:21], 1'b0};
               default:                                   // I form, meaningless for R
                  o_imm = {{(`XLEN-11){i_instr[31]}}, i_instr[30:20]};
            endcase
         end
         QUAD_C2: begin
            // c.lwsp offset[7:6|5|4:2], word scaled, zero extended
            if (c_funct3 == C2_LWSP)
               o_imm = {{(`XLEN-8){1'b0}}, i_instr[3:2], i_instr[12], i_instr[6:4], 2'b00};
         end
         default: o_imm = '0;                             // c0 and c1 carry no imm here
      endcase
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
riscv_isa_pkg.sv
exec_ctrl_pkg.sv
rv_imm_gen.sv
rv_base_ctrl_dec.sv
rv_compressed_ctrl_dec.sv
rv_decode_reg.sv
rv_decoder.sv
tb_rv_decoder.sv

// File: tb_rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "decoder_consts.svh"

module tb_rv_decoder
   import riscv_isa_pkg::*;
   import exec_ctrl_pkg::*;
();

   localparam int MAX_CASES     = 64;
   localparam int VALID_TIMEOUT = 20;                     // cycles per wait for o_valid
   localparam int DRIVE_DELAY   = 1;                      // ns after rising edge

   typedef struct packed {
      logic [`XLEN-1:0]          instr;
      reg_sel_t                  regs;
      logic [`XLEN-1:0]          imm;
      logic [`BRANCH_MASK_W-1:0] branch_mask;
      funct3_t                   funct3;
      dec_ctrl_t                 ctrl;
   } dec_case_t;

   logic                      i_clk;
   logic                      i_rst_n;
   logic                      i_en;
   logic [`XLEN-1:0]          i_instr;
   logic                      o_valid;
   reg_sel_t                  o_regs;
   logic [`XLEN-1:0]          o_imm;
   logic [`BRANCH_MASK_W-1:0] o_branch_mask;
   funct3_t                   o_funct3;
   dec_ctrl_t                 o_ctrl;

   dec_case_t cases [MAX_CASES];
   int        num_cases;
   int        value_errors;
   int        timeout_errors;
   int        file_errors;

   rv_decoder rv_decoder_inst (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_en          (i_en),
      .i_instr       (i_instr),
      .o_valid       (o_valid),
      .o_regs        (o_regs),
      .o_imm         (o_imm),
      .o_branch_mask (o_branch_mask),
      .o_funct3      (o_funct3),
      .o_ctrl        (o_ctrl)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;                          // 4 ns period
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin                      // x or z also mismatch
         value_errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_outputs(input dec_case_t exp_case);
      check_value("o_regs.rs1", 32'(exp_case.regs.rs1), 32'(o_regs.rs1));
      check_value("o_regs.rs2", 32'(exp_case.regs.rs2), 32'(o_regs.rs2));
      check_value("o_regs.rd", 32'(exp_case.regs.rd), 32'(o_regs.rd));
      check_value("o_imm", exp_case.imm, o_imm);
      check_value("o_branch_mask", 32'(exp_case.branch_mask), 32'(o_branch_mask));
      check_value("o_funct3", 32'(exp_case.funct3), 32'(o_funct3));
      check_value("o_ctrl.alu_oper", 32'(exp_case.ctrl.alu_oper), 32'(o_ctrl.alu_oper));
      check_value("o_ctrl.s1_sel", 32'(exp_case.ctrl.s1_sel), 32'(o_ctrl.s1_sel));
      check_value("o_ctrl.s2_sel", 32'(exp_case.ctrl.s2_sel), 32'(o_ctrl.s2_sel));
      check_value("o_ctrl.next_stage", 32'(exp_case.ctrl.next_stage), 32'(o_ctrl.next_stage));
      check_value("o_ctrl.wb_from_alu", 32'(exp_case.ctrl.wb_from_alu),
                  32'(o_ctrl.wb_from_alu));
      check_value("o_ctrl.wb_from_imm", 32'(exp_case.ctrl.wb_from_imm),
                  32'(o_ctrl.wb_from_imm));
      check_value("o_ctrl.next_pc_from_alu", 32'(exp_case.ctrl.next_pc_from_alu),
                  32'(o_ctrl.next_pc_from_alu));
      check_value("o_ctrl.reg_input_sel", 32'(exp_case.ctrl.reg_input_sel),
                  32'(o_ctrl.reg_input_sel));
      check_value("o_ctrl.write_reg", 32'(exp_case.ctrl.write_reg), 32'(o_ctrl.write_reg));
   endtask

   task automatic load_cases();
      int          fd;
      int          fields;
      string       line;
      logic [31:0] instr;
      logic [31:0] rs1;
      logic [31:0] rs2;
      logic [31:0] rd;
      logic [31:0] imm;
      logic [31:0] mask;
      logic [31:0] f3;
      logic [31:0] ctrl;
      num_cases = 0;
      fd = $fopen("decoder_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open case file decoder_cases.txt");
         file_errors++;
         return;
      end
      while (num_cases < MAX_CASES) begin
         if ($fgets(line, fd) == 0)
            break;                                        // end of file
         if (line.len() < 2 || line.getc(0) == "#")
            continue;                                     // blank or comment line
         fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                          instr, rs1, rs2, rd, imm, mask, f3, ctrl);
         if (fields != 8) begin
            $display("malformed line in case file: %s", line);
            file_errors++;
            continue;
         end
         cases[num_cases].instr       = instr;
         cases[num_cases].regs        = '{rs1: rs1[4:0], rs2: rs2[4:0], rd: rd[4:0]};
         cases[num_cases].imm         = imm;
         cases[num_cases].branch_mask = mask[`BRANCH_MASK_W-1:0];
         cases[num_cases].funct3      = f3[2:0];
         cases[num_cases].ctrl        = ctrl[$bits(dec_ctrl_t)-1:0];
         num_cases++;
      end
      $fclose(fd);
      if (num_cases == 0) begin
         $display("case file holds no usable cases");
         file_errors++;
      end
   endtask

   // one enable and its result followed by a random idle gap
   task automatic run_single_case(input int idx);
      int waited;
      int gap;
      i_en    = 1'b1;
      i_instr = cases[idx].instr;
      waited  = 0;
      do begin
         @(posedge i_clk);
         #DRIVE_DELAY;
         i_en    = 1'b0;                                  // exactly one enable edge
         i_instr = ~cases[idx].instr;                     // a different word on the idle bus
         waited++;
      end while (!o_valid && waited < VALID_TIMEOUT);
      if (!o_valid) begin
         $display("no valid output for instruction %h", cases[idx].instr);
         timeout_errors++;
      end else begin
         check_value("o_valid latency", 1, waited);
         check_outputs(cases[idx]);
      end
      gap = $urandom % 4;
      for (int g = 0; g < gap; g++) begin
         @(posedge i_clk);
         #DRIVE_DELAY;
         check_value("o_valid", 0, 32'(o_valid));         // idle with outputs held
         check_outputs(cases[idx]);
      end
   endtask

   // enables on consecutive cycles with result i one edge after its enable
   task automatic stream_cases();
      i_en    = 1'b1;
      i_instr = cases[0].instr;
      for (int i = 0; i < num_cases; i++) begin
         @(posedge i_clk);
         #DRIVE_DELAY;
         if (i + 1 < num_cases) begin
            i_instr = cases[i + 1].instr;
         end else begin
            i_en    = 1'b0;
            i_instr = ~cases[i].instr;
         end
         check_value("o_valid", 1, 32'(o_valid));
         check_outputs(cases[i]);
      end
      repeat (3) begin
         @(posedge i_clk);
         #DRIVE_DELAY;
         check_value("o_valid", 0, 32'(o_valid));
         check_outputs(cases[num_cases - 1]);             // last result held
      end
   endtask

   initial begin
      void'($urandom(45637));
      i_rst_n        = 1'b0;
      i_en           = 1'b0;
      i_instr        = '0;
      value_errors   = 0;
      timeout_errors = 0;
      file_errors    = 0;
      load_cases();
      repeat (16) @(posedge i_clk);
      #DRIVE_DELAY;
      i_rst_n = 1'b1;
      check_value("o_valid", 0, 32'(o_valid));            // reset state before any enable
      check_value("o_ctrl.write_reg", 0, 32'(o_ctrl.write_reg));
      check_value("o_ctrl.wb_from_alu", 0, 32'(o_ctrl.wb_from_alu));
      check_value("o_ctrl.wb_from_imm", 0, 32'(o_ctrl.wb_from_imm));
      check_value("o_ctrl.next_pc_from_alu", 0, 32'(o_ctrl.next_pc_from_alu));
      check_value("o_ctrl.next_stage", 32'(EXEC_TO_FETCH), 32'(o_ctrl.next_stage));
      for (int i = 0; i < num_cases; i++)
         run_single_case(i);
      if (num_cases > 0)
         stream_cases();
      $display("errors: %0d value mismatches, %0d timeouts, %0d case file problems",
               value_errors, timeout_errors, file_errors);
      if (value_errors + timeout_errors + file_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
